// ==== arithUnitPkg.sv ====
////////////////////////////////////////
// Shared widths, opcodes and the command
// byte layout of the 16-bit arithmetic unit.
// Every design module takes it by a wildcard
// import in its header.
////////////////////////////////////////
`default_nettype none

package arithUnitPkg;

  localparam int regWidth  = 16;
  localparam int byteWidth = 8;
  localparam int mulSteps  = 8;
  localparam int stepWidth = 3;

  // Opcodes in command bits 6..5
  localparam logic [1:0] opLoad = 2'b00;
  localparam logic [1:0] opAdd  = 2'b01;
  localparam logic [1:0] opSub  = 2'b10;
  localparam logic [1:0] opMul  = 2'b11;

  // Command byte as seen by a load
  typedef struct packed {
    logic       signedMode;
    logic [1:0] op;
    logic [1:0] regSel;
    logic       rw;
    logic       start;
    logic       unused;
  } loadViewT;

  // Same byte as seen by add, sub and mul
  typedef struct packed {
    logic       signedMode;
    logic [1:0] op;
    logic [1:0] unusedHi;
    logic       useA;
    logic       start;
    logic       unusedLo;
  } arithViewT;

  // Bit 2 is rw for loads and useA otherwise
  typedef union packed {
    loadViewT  loadView;
    arithViewT arithView;
  } cmdWordT;

endpackage

`default_nettype wire

// ==== cmdSequencer.sv ====
////////////////////////////////////////
// Control of the arithmetic unit. Accepts a
// started command while idle, drives the
// register and flag enables and steps the
// 8-cycle shift-and-add multiply.
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cmdSequencer
  import arithUnitPkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  cmdWordT              cmd,
  input  logic                 operandBit,
  output logic                 busy,
  output logic                 done,
  output logic                 loadA,
  output logic                 loadB,
  output logic                 loadHigh,
  output logic                 readLatch,
  output logic                 accClear,
  output logic                 accWrite,
  output logic                 useA,
  output logic                 signedMode,
  output logic                 subtract,
  output logic                 mulMode,
  output logic                 flagLoad,
  output logic [stepWidth-1:0] step
);

  logic       accept;
  logic       isLoad;
  logic       isArith;
  logic       isMul;
  logic       lastStep;
  logic       signedReg;
  logic       useAReg;
  logic [1:0] opReg;
  logic [1:0] curOp;

  // Start counts only while idle
  assign accept   = cmd.loadView.start && !busy;
  assign isLoad   = cmd.loadView.op == opLoad;
  assign isArith  = (cmd.arithView.op == opAdd) || (cmd.arithView.op == opSub);
  assign isMul    = cmd.arithView.op == opMul;
  assign lastStep = busy && (step == stepWidth'(mulSteps - 1));

  // Live command when idle, captured one during multiply
  assign curOp      = busy ? opReg : cmd.arithView.op;
  assign signedMode = busy ? signedReg : cmd.arithView.signedMode;
  assign useA       = busy ? useAReg : cmd.arithView.useA;
  assign mulMode    = curOp == opMul;

  ////////////////////////////////////////
  // Register enables
  assign loadA     = accept && isLoad && cmd.loadView.rw && !cmd.loadView.regSel[1];
  assign loadB     = accept && isLoad && cmd.loadView.rw && cmd.loadView.regSel[1];
  assign loadHigh  = cmd.loadView.regSel[0];
  assign readLatch = accept && isLoad && !cmd.loadView.rw;
  assign accClear  = accept && isMul;
  // Partial product only when the operand bit is set
  assign accWrite  = (accept && isArith) || (busy && operandBit);

  // Signed multiply subtracts its top partial product
  assign subtract = (curOp == opSub) || (lastStep && signedReg);
  assign flagLoad = (accept && isArith) || lastStep;

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      opReg     <= opLoad;
      signedReg <= 1'b0;
      useAReg   <= 1'b0;
    end
    else if (accept)
    begin
      opReg     <= cmd.arithView.op;
      signedReg <= cmd.arithView.signedMode;
      useAReg   <= cmd.arithView.useA;
    end
  end

  ////////////////////////////////////////
  // Step counter, busy and done
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      busy <= 1'b0;
      done <= 1'b0;
      step <= '0;
    end
    else
    begin
      done <= (accept && !isMul) || lastStep;
      if (accept && isMul)
      begin
        busy <= 1'b1;
        step <= '0;
      end
      else if (busy)
      begin
        // Wraps back to 0 after the last step
        step <= step + 1'b1;
        if (lastStep)
          busy <= 1'b0;
      end
    end
  end

  // Opcode captured at acceptance keeps the multiply selected
  assert property (@(posedge CLK) disable iff (!RST) busy |-> mulMode)
    else $error("busy without multiply opcode");

  assert property (@(posedge CLK) disable iff (!RST) !(done && busy))
    else $error("done raised while busy");

endmodule

`default_nettype wire

// ==== operandRegs.sv ====
////////////////////////////////////////
// Working registers A and B with their byte
// load paths, the read select register and
// the byte multiplexer onto dataOut.
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module operandRegs
  import arithUnitPkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic [byteWidth-1:0] operand,
  input  logic [1:0]           regSel,
  input  logic                 loadA,
  input  logic                 loadB,
  input  logic                 loadHigh,
  input  logic                 readLatch,
  input  logic                 accClear,
  input  logic                 accWrite,
  input  logic [regWidth-1:0]  sum,
  output logic [regWidth-1:0]  regA,
  output logic [regWidth-1:0]  regB,
  output logic [byteWidth-1:0] dataOut
);

  logic [1:0] readSel;

  ////////////////////////////////////////
  // Register A, byte loads only
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      regA <= '0;
    else if (loadA)
    begin
      if (loadHigh)
        regA[regWidth-1:byteWidth] <= operand;
      else
        regA[byteWidth-1:0] <= operand;
    end
  end

  ////////////////////////////////////////
  // Register B, also the accumulator
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      regB <= '0;
    else if (accClear)
      regB <= '0;
    else if (accWrite)
      regB <= sum;
    else if (loadB)
    begin
      if (loadHigh)
        regB[regWidth-1:byteWidth] <= operand;
      else
        regB[byteWidth-1:0] <= operand;
    end
  end

  // Read select, 00 A low up to 11 B high
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      readSel <= 2'b00;
    else if (readLatch)
      readSel <= regSel;
  end

  always_comb
  begin
    case (readSel)
      2'b00:   dataOut = regA[byteWidth-1:0];
      2'b01:   dataOut = regA[regWidth-1:byteWidth];
      2'b10:   dataOut = regB[byteWidth-1:0];
      default: dataOut = regB[regWidth-1:byteWidth];
    endcase
  end

  // Sequencer must never load and accumulate B together
  assert property (@(posedge CLK) disable iff (!RST) !(loadB && accWrite))
    else $error("loadB and accWrite both active");

endmodule

`default_nettype wire

// ==== adderPath.sv ====
////////////////////////////////////////
// Addend selection, the 16-bit adder with
// carry-in and the overflow and negative
// flag registers.
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module adderPath
  import arithUnitPkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic [regWidth-1:0]  regA,
  input  logic [regWidth-1:0]  regB,
  input  logic [byteWidth-1:0] operand,
  input  logic                 useA,
  input  logic                 signedMode,
  input  logic                 subtract,
  input  logic                 mulMode,
  input  logic [stepWidth-1:0] step,
  input  logic                 flagLoad,
  output logic [regWidth-1:0]  sum,
  output logic                 overflow,
  output logic                 negative
);

  logic [regWidth-1:0] opExt;
  logic [regWidth-1:0] aLowExt;
  logic [regWidth-1:0] mulTerm;
  logic [regWidth-1:0] srcX;
  logic [regWidth-1:0] addend;
  logic                carryOut;
  logic                ovfNext;
  logic                negNext;

  // Sign or zero extension of the byte sources
  assign opExt   = {{(regWidth - byteWidth){signedMode & operand[byteWidth-1]}}, operand};
  assign aLowExt = {{(regWidth - byteWidth){signedMode & regA[byteWidth-1]}},
                    regA[byteWidth-1:0]};

  // Zero term for a clear operand bit, so sum equals B then
  assign mulTerm = operand[step] ? (aLowExt << step) : '0;

  ////////////////////////////////////////
  // Adder, B plus or minus the addend
  assign srcX   = mulMode ? mulTerm : (useA ? regA : opExt);
  assign addend = subtract ? ~srcX : srcX;
  assign {carryOut, sum} = {1'b0, regB} + {1'b0, addend} + {{regWidth{1'b0}}, subtract};

  always_comb
  begin
    if (mulMode)
    begin
      ovfNext = 1'b0;
      negNext = signedMode & sum[regWidth-1];
    end
    else if (signedMode)
    begin
      // Same input signs, different result sign
      ovfNext = (regB[regWidth-1] == addend[regWidth-1]) &&
                (sum[regWidth-1] != regB[regWidth-1]);
      negNext = sum[regWidth-1];
    end
    else
    begin
      ovfNext = !subtract && carryOut;
      negNext = subtract && !carryOut;
    end
  end

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      overflow <= 1'b0;
      negative <= 1'b0;
    end
    else if (flagLoad)
    begin
      overflow <= ovfNext;
      negative <= negNext;
    end
  end

endmodule

`default_nettype wire

// ==== arithUnit.sv ====
////////////////////////////////////////
// Top of the 16-bit arithmetic unit. Joins
// the sequencer, the working registers and
// the adder path.
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module arithUnit
  import arithUnitPkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  cmdWordT              cmd,
  input  logic [byteWidth-1:0] operand,
  output logic [byteWidth-1:0] dataOut,
  output logic                 overflow,
  output logic                 negative,
  output logic                 done,
  output logic                 busy
);

  logic                 loadA;
  logic                 loadB;
  logic                 loadHigh;
  logic                 readLatch;
  logic                 accClear;
  logic                 accWrite;
  logic                 useA;
  logic                 signedMode;
  logic                 subtract;
  logic                 mulMode;
  logic                 flagLoad;
  logic [stepWidth-1:0] step;
  logic [regWidth-1:0]  regA;
  logic [regWidth-1:0]  regB;
  logic [regWidth-1:0]  sum;

  cmdSequencer seq_i (
    .CLK        (CLK),
    .RST        (RST),
    .cmd        (cmd),
    .operandBit (operand[step]),
    .busy       (busy),
    .done       (done),
    .loadA      (loadA),
    .loadB      (loadB),
    .loadHigh   (loadHigh),
    .readLatch  (readLatch),
    .accClear   (accClear),
    .accWrite   (accWrite),
    .useA       (useA),
    .signedMode (signedMode),
    .subtract   (subtract),
    .mulMode    (mulMode),
    .flagLoad   (flagLoad),
    .step       (step)
  );

  operandRegs regs_i (
    .CLK       (CLK),
    .RST       (RST),
    .operand   (operand),
    .regSel    (cmd.loadView.regSel),
    .loadA     (loadA),
    .loadB     (loadB),
    .loadHigh  (loadHigh),
    .readLatch (readLatch),
    .accClear  (accClear),
    .accWrite  (accWrite),
    .sum       (sum),
    .regA      (regA),
    .regB      (regB),
    .dataOut   (dataOut)
  );

  adderPath adder_i (
    .CLK        (CLK),
    .RST        (RST),
    .regA       (regA),
    .regB       (regB),
    .operand    (operand),
    .useA       (useA),
    .signedMode (signedMode),
    .subtract   (subtract),
    .mulMode    (mulMode),
    .step       (step),
    .flagLoad   (flagLoad),
    .sum        (sum),
    .overflow   (overflow),
    .negative   (negative)
  );

endmodule

`default_nettype wire

// ==== tbClock.sv ====
////////////////////////////////////////
// Free-running testbench clock, 20 ns
// period, starting low.
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tbClock (
  output logic CLK
);

  initial
  begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

endmodule

`default_nettype wire

// ==== arithUnitTb.sv ====
////////////////////////////////////////
// Testbench of the 16-bit arithmetic unit.
// Reads one command per line from the
// data file, drives it on the falling edge,
// waits for done and compares the outputs.
// A cycle counter bounds the whole run.
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module arithUnitTb;

  localparam string dataFile      = "arithUnit_testdata.txt";
  localparam int    resetCycles   = 16;
  localparam int    cyclesPerLine = 14;
  localparam int    timeoutMargin = 40;

  logic       CLK;
  logic       RST;
  logic [7:0] cmd;
  logic [7:0] operand;
  logic [7:0] dataOut;
  logic       overflow;
  logic       negative;
  logic       done;
  logic       busy;

  // One entry per data line
  string      names[$];
  logic [7:0] cmdList[$];
  logic [7:0] operandList[$];
  logic [7:0] flagList[$];
  logic [7:0] expDataList[$];
  logic       expOvfList[$];
  logic       expNegList[$];

  integer seed;
  int     cycleCount = 0;
  int     cycleLimit = 0;

  tbClock clk_i (
    .CLK (CLK)
  );

  arithUnit dut_i (
    .CLK      (CLK),
    .RST      (RST),
    .cmd      (cmd),
    .operand  (operand),
    .dataOut  (dataOut),
    .overflow (overflow),
    .negative (negative),
    .done     (done),
    .busy     (busy)
  );

  ////////////////////////////////////////
  // Helpers
  task automatic checkValue(string testName, string what, int expected, int actual);
    assert (expected == actual)
    else
    begin
      $display("ERR %s: %s expected %0h actual %0h", testName, what, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic loadVectors();
    integer     fd;
    int         status;
    int         count;
    string      line;
    string      name;
    logic [7:0] c;
    logic [7:0] o;
    logic [7:0] f;
    logic [7:0] d;
    logic [7:0] v;
    logic [7:0] g;
    fd = $fopen(dataFile, "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file %s", dataFile);
      $display("Simulation FAILED");
      $fatal(1, "missing stimulus file");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        status = $fgets(line, fd);
        // Skip blank lines and comments
        if (status == 0 || line.len() < 2 || line.getc(0) == "#")
          continue;
        count = $sscanf(line, "%s %h %h %h %h %h %h", name, c, o, f, d, v, g);
        if (count != 7)
        begin
          $display("Malformed stimulus line: %s", line);
          $display("Simulation FAILED");
          $fatal(1, "bad stimulus line");
        end
        else
        begin
          names.push_back(name);
          cmdList.push_back(c);
          operandList.push_back(o);
          flagList.push_back(f);
          expDataList.push_back(d);
          expOvfList.push_back(v[0]);
          expNegList.push_back(g[0]);
        end
      end
      $fclose(fd);
    end
  endtask

  // Flag bit 0 asks for a compare, bit 1 repeats the start while busy
  task automatic runStep(int idx);
    logic [7:0] stepCmd;
    logic       isMul;
    int         latency;
    int         busyCycles;
    bit         poked;
    stepCmd    = cmdList[idx];
    isMul      = stepCmd[6:5] == 2'b11;
    busyCycles = 0;
    poked      = 1'b0;
    cmd        = stepCmd;
    operand    = operandList[idx];
    @(negedge CLK);
    cmd     = 8'h00;
    latency = 1;
    while (!done)
    begin
      if (busy)
        busyCycles++;
      if (flagList[idx][1] && busy && busyCycles == 3 && !poked)
      begin
        cmd   = stepCmd;
        poked = 1'b1;
      end
      else
        cmd = 8'h00;
      @(negedge CLK);
      latency++;
    end
    cmd = 8'h00;
    // Busy already low in the done cycle
    if (busy)
      busyCycles++;
    // Multiply needs 8 steps plus the done cycle
    checkValue(names[idx], "latency", isMul ? 9 : 1, latency);
    checkValue(names[idx], "busy cycles", isMul ? 8 : 0, busyCycles);
    if (flagList[idx][0])
    begin
      checkValue(names[idx], "dataOut", int'(expDataList[idx]), int'(dataOut));
      checkValue(names[idx], "overflow", int'(expOvfList[idx]), int'(overflow));
      checkValue(names[idx], "negative", int'(expNegList[idx]), int'(negative));
    end
  endtask

  task automatic idleGap();
    int gap;
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) @(negedge CLK);
  endtask

  ////////////////////////////////////////
  // Run limit
  always @(posedge CLK)
  begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit)
    begin
      $display("Timeout: no done within %0d cycles", cycleLimit);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    seed    = 53577;
    RST     = 1'b0;
    cmd     = 8'h00;
    operand = 8'h00;
    loadVectors();
    cycleLimit = names.size() * cyclesPerLine + timeoutMargin;
    repeat (resetCycles) @(negedge CLK);
    RST = 1'b1;
    @(negedge CLK);
    for (int i = 0; i < names.size(); i++)
    begin
      runStep(i);
      idleGap();
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== arithUnit_testdata.txt ====
# name cmd operand flags dataOut overflow negative, all hex
# flags bit0 compares outputs, bit1 repeats the start while busy
ldAlo 06 34 1 34 0 0
ldAhi 0E 12 1 34 0 0
ldBlo 16 78 1 34 0 0
ldBhi 1E 56 1 34 0 0
rdAlo 02 00 1 34 0 0
rdAhi 0A 00 1 12 0 0
rdBlo 12 00 1 78 0 0
rdBhi 1A 00 1 56 0 0
ldBhiFF 1E FF 1 FF 0 0
ldBloF0 16 F0 1 FF 0 0
addUnsCarry 22 20 1 00 1 0
rdSumLo 12 00 1 10 1 0
addUnsA 26 00 1 44 0 0
rdSumHi 1A 00 1 12 0 0
subUns 42 45 1 11 0 0
subUnsABorrow 46 00 1 FF 0 1
rdDiffLo 12 00 1 CB 0 1
ldBhi7F 1E 7F 1 CB 0 1
ldBloF0b 16 F0 1 F0 0 1
addSgnOvf A2 20 1 10 1 1
subSgnOvf C2 30 1 E0 1 0
ldBhi00 1E 00 1 E0 1 0
ldBlo05 16 05 1 05 1 0
addSgnNeg A2 F0 1 F5 0 1
subSgnNeg C2 FE 1 F7 0 1
rdNegHi 1A 00 1 FF 0 1
mulUns 62 C5 1 28 0 0
rdProdLo 12 00 1 04 0 0
rdAloKeep 02 00 1 34 0 0
rdAhiKeep 0A 00 1 12 0 0
ldAloF9 06 F9 1 12 0 0
mulSgnNeg E2 0D 1 12 0 1
rdSgnHi 1A 00 1 FF 0 1
rdSgnLo 12 00 1 A5 0 1
addSetOvf 22 60 1 05 1 0
mulSgnBothNeg E2 FA 1 2A 0 0
rdSgnHi2 1A 00 1 00 0 0
mulBusyStart 62 03 3 02 0 0
rdBusyLo 12 00 1 EB 0 0

// ==== arithUnit.f ====
arithUnitPkg.sv
cmdSequencer.sv
operandRegs.sv
adderPath.sv
arithUnit.sv
tbClock.sv
arithUnitTb.sv

// ==== Makefile ====
# Verilator lint and simulation of the arithmetic unit

TOP := arithUnitTb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f arithUnit.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f arithUnit.f \
		--top-module $(TOP) -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
